//--- trap_unit_top.f
source/csr_pkg.sv
source/sys_op_pkg.sv
source/sys_decoder.sv
source/csr_file.sv
source/sys_exec_ctrl.sv
source/trap_unit_top.sv
verification/tb_trap_unit.sv

//--- Makefile
# Verilator build and run of the trap unit testbench

VERILATOR ?= verilator
TOP       ?= tb_trap_unit
FILELIST  ?= trap_unit_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/tb_trap_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_trap_unit
  import csr_pkg::*;
  import sys_op_pkg::*;
();

  localparam int          XLEN        = 32;
  localparam logic [31:0] MTVEC_RESET = 32'h0000_0100;
  // 16 rw + 40 set/clear + 18 trap + 14 illegal
  localparam int          NUM_DIRECTED   = 88;
  localparam int          NUM_RANDOM     = 80;
  localparam int          TIMEOUT_CYCLES = 40 * (NUM_DIRECTED + NUM_RANDOM);

  // fixed privileged encodings, wfi is not handled and must come back illegal
  localparam logic [31:0] ECALL_INSTR = {12'h000, 5'd0, FUNCT3_PRIV, 5'd0, OPC_SYSTEM};
  localparam logic [31:0] MRET_INSTR  = {12'h302, 5'd0, FUNCT3_PRIV, 5'd0, OPC_SYSTEM};
  localparam logic [31:0] WFI_INSTR   = {12'h105, 5'd0, FUNCT3_PRIV, 5'd0, OPC_SYSTEM};

  logic            clk;
  logic            i_rst_n;
  logic            i_req;
  logic [31:0]     i_instr;
  logic [XLEN-1:0] i_pc;
  logic [XLEN-1:0] i_rs1_data;
  logic            o_ack;
  logic [XLEN-1:0] o_rd_data;
  logic            o_redirect;
  logic [XLEN-1:0] o_target_pc;
  logic            o_illegal;

  // reference copy of the four csrs
  logic [31:0] ref_mstatus;
  logic [31:0] ref_mtvec;
  logic [31:0] ref_mepc;
  logic [31:0] ref_mcause;

  // expected response of the request in flight
  logic [31:0] exp_rd       = '0;
  logic        exp_redirect = 1'b0;
  logic [31:0] exp_target   = '0;
  logic        exp_illegal  = 1'b0;

  logic [31:0] lcg_state = 32'hfab27e15;
  logic [11:0] csr_list     [0:3];
  logic [11:0] unknown_list [0:3];
  logic [2:0]  csr_funct3   [0:5];
  int          error_count = 0;
  int          txn_count   = 0;
  int          cycle_count;

  trap_unit_top #(
    .XLEN        (XLEN),
    .MTVEC_RESET (MTVEC_RESET)
  ) UUT (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_req       (i_req),
    .i_instr     (i_instr),
    .i_pc        (i_pc),
    .i_rs1_data  (i_rs1_data),
    .o_ack       (o_ack),
    .o_rd_data   (o_rd_data),
    .o_redirect  (o_redirect),
    .o_target_pc (o_target_pc),
    .o_illegal   (o_illegal)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // lcg, halves swapped so the low bits are usable
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  function automatic logic [31:0] rand_pc();
    return next_rand() & 32'hffff_fffc;
  endfunction

  function automatic logic [31:0] encode_csr(input logic [2:0] funct3, input logic [11:0] addr,
                                              input logic [4:0] src, input logic [4:0] rd);
    return {addr, src, funct3, rd, OPC_SYSTEM};
  endfunction

  // model read, top bit flags a known address
  function automatic logic [32:0] lookup_csr(input logic [11:0] addr);
    case (addr)
      MSTATUS: return {1'b1, ref_mstatus};
      MTVEC:   return {1'b1, ref_mtvec};
      MEPC:    return {1'b1, ref_mepc};
      MCAUSE:  return {1'b1, ref_mcause};
      default: return {1'b0, 32'd0};
    endcase
  endfunction

  task automatic store_csr(input logic [11:0] addr, input logic [31:0] value);
    case (addr)
      MSTATUS: ref_mstatus = value;
      MTVEC:   ref_mtvec   = value;
      MEPC:    ref_mepc    = value;
      default: ref_mcause  = value;
    endcase
  endtask

  // expected outputs from the old model state, then the model moves on
  task automatic predict(input logic [31:0] instr, input logic [31:0] rs1,
                         input logic [31:0] pc);
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [4:0]  src;
    logic [4:0]  rd;
    logic [11:0] field12;
    logic        valid;
    logic [31:0] old_val;
    logic [31:0] operand;
    opcode       = instr[6:0];
    rd           = instr[11:7];
    funct3       = instr[14:12];
    src          = instr[19:15];
    field12      = instr[31:20];
    exp_rd       = '0;
    exp_redirect = 1'b0;
    exp_target   = '0;
    exp_illegal  = 1'b0;
    if (opcode != OPC_SYSTEM) begin
      exp_illegal = 1'b1;
    end else if (funct3 == FUNCT3_PRIV) begin
      if (src != 5'd0 || rd != 5'd0) begin
        exp_illegal = 1'b1;
      end else if (field12 == 12'h000) begin
        // ecall, direct mode base
        exp_redirect              = 1'b1;
        exp_target                = {ref_mtvec[31:2], 2'b00};
        ref_mepc                  = pc;
        ref_mcause                = 32'd11;
        ref_mstatus[MSTATUS_MPIE] = ref_mstatus[MSTATUS_MIE];
        ref_mstatus[MSTATUS_MIE]  = 1'b0;
        ref_mstatus[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = 2'b11;
      end else if (field12 == 12'h302) begin
        // mret back to mepc
        exp_redirect              = 1'b1;
        exp_target                = ref_mepc;
        ref_mstatus[MSTATUS_MIE]  = ref_mstatus[MSTATUS_MPIE];
        ref_mstatus[MSTATUS_MPIE] = 1'b1;
        ref_mstatus[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = 2'b00;
      end else begin
        exp_illegal = 1'b1;
      end
    end else if (funct3 == 3'b100) begin
      exp_illegal = 1'b1;
    end else begin
      {valid, old_val} = lookup_csr(field12);
      if (!valid) begin
        exp_illegal = 1'b1;
      end else begin
        // bit 2 picks the zero-extended uimm
        operand = funct3[2] ? {27'd0, src} : rs1;
        exp_rd  = old_val;
        case (funct3[1:0])
          2'b01: store_csr(field12, operand);
          2'b10: begin
            if (src != 5'd0) begin
              store_csr(field12, old_val | operand);
            end
          end
          default: begin
            if (src != 5'd0) begin
              store_csr(field12, old_val & ~operand);
            end
          end
        endcase
      end
    end
  endtask

  // one four-phase transaction, entered 2 ns after an edge
  task automatic transact(input logic [31:0] instr, input logic [31:0] rs1,
                          input logic [31:0] pc);
    logic [31:0] r;
    logic [2:0]  hold;
    logic [1:0]  gap;
    r          = next_rand();
    hold       = {1'b0, r[1:0]} + 3'd1;
    gap        = r[3:2];
    predict(instr, rs1, pc);
    i_instr    = instr;
    i_pc       = pc;
    i_rs1_data = rs1;
    i_req      = 1'b1;
    @(posedge clk);
    #2;
    // bounded by the cycle counter below
    while (!o_ack) begin
      @(posedge clk);
      #2;
    end
    // ack has to be sampled with req still high
    repeat (hold) @(posedge clk);
    #2;
    i_req      = 1'b0;
    // bus is free again, garbage here
    i_instr    = next_rand();
    i_pc       = next_rand();
    i_rs1_data = next_rand();
    @(posedge clk);
    #2;
    while (o_ack) begin
      @(posedge clk);
      #2;
    end
    repeat (gap) begin
      @(posedge clk);
      #2;
    end
    txn_count++;
  endtask

  // csrrs with x0, a pure read
  task automatic read_csr(input logic [11:0] addr);
    transact(encode_csr(FUNCT3_CSRRS, addr, 5'd0, 5'd10), next_rand(), rand_pc());
  endtask

  task automatic readback_csrs();
    for (int i = 0; i < 4; i++) begin
      read_csr(csr_list[i]);
    end
  endtask

  // results against the model while acked
  a_result: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_ack |-> (o_rd_data == exp_rd) && (o_illegal == exp_illegal) &&
              (o_redirect == exp_redirect))
    else begin
      error_count++;
      $display("[FAIL] %0t: rd %h illegal %b redirect %b, expected rd %h illegal %b redirect %b",
               $time, o_rd_data, o_illegal, o_redirect, exp_rd, exp_illegal, exp_redirect);
    end

  a_target: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_ack && exp_redirect |-> o_target_pc == exp_target)
    else begin
      error_count++;
      $display("[FAIL] %0t: target pc %h, expected %h", $time, o_target_pc, exp_target);
    end

  // req first sampled two edges back
  a_ack_after_two: assert property (@(posedge clk) disable iff (!i_rst_n)
    $past(i_req, 2) && !$past(i_req, 3) |-> o_ack && !$past(o_ack))
    else begin
      error_count++;
      $display("[FAIL] %0t: ack did not rise two edges after req", $time);
    end

  a_ack_source: assert property (@(posedge clk) disable iff (!i_rst_n)
    $rose(o_ack) |-> i_req && $past(i_req, 2) && !$past(i_req, 3))
    else begin
      error_count++;
      $display("[FAIL] %0t: ack rose without a matching req", $time);
    end

  a_ack_fall: assert property (@(posedge clk) disable iff (!i_rst_n)
    $past(i_req, 2) && !$past(i_req) |-> !o_ack && $past(o_ack))
    else begin
      error_count++;
      $display("[FAIL] %0t: ack did not fall one edge after req dropped", $time);
    end

  // frozen outputs under back-pressure
  a_hold_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_ack && $past(o_ack) |-> $stable(o_rd_data) && $stable(o_redirect) &&
                              $stable(o_target_pc) && $stable(o_illegal))
    else begin
      error_count++;
      $display("[FAIL] %0t: outputs changed while ack was held", $time);
    end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("tests failed");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [31:0] word;
    logic [4:0]  src;
    logic [2:0]  f3;
    i_rst_n         = 1'b0;
    i_req           = 1'b0;
    i_instr         = '0;
    i_pc            = '0;
    i_rs1_data      = '0;
    ref_mstatus     = '0;
    ref_mtvec       = MTVEC_RESET;
    ref_mepc        = '0;
    ref_mcause      = '0;
    csr_list[0]     = MSTATUS;
    csr_list[1]     = MTVEC;
    csr_list[2]     = MEPC;
    csr_list[3]     = MCAUSE;
    // mie, misa, mip, cycle
    unknown_list[0] = 12'h304;
    unknown_list[1] = 12'h301;
    unknown_list[2] = 12'h344;
    unknown_list[3] = 12'hc00;
    csr_funct3[0]   = FUNCT3_CSRRW;
    csr_funct3[1]   = FUNCT3_CSRRS;
    csr_funct3[2]   = FUNCT3_CSRRC;
    csr_funct3[3]   = FUNCT3_CSRRWI;
    csr_funct3[4]   = FUNCT3_CSRRSI;
    csr_funct3[5]   = FUNCT3_CSRRCI;
    repeat (10) @(posedge clk);
    #2;
    i_rst_n = 1'b1;
    a_reset_outputs: assert (!o_ack && !o_redirect && !o_illegal &&
                             o_rd_data == '0 && o_target_pc == '0)
      else begin
        error_count++;
        $display("[FAIL] %0t: outputs not cleared by reset", $time);
      end

    // plain writes, old value back, then read the new one
    for (int i = 0; i < 4; i++) begin
      transact(encode_csr(FUNCT3_CSRRW, csr_list[i], 5'd7, 5'd5), next_rand(), rand_pc());
      read_csr(csr_list[i]);
      r = next_rand();
      transact(encode_csr(FUNCT3_CSRRWI, csr_list[i], r[4:0], 5'd5), next_rand(), rand_pc());
      read_csr(csr_list[i]);
    end

    // set and clear, register and uimm forms
    for (int i = 0; i < 4; i++) begin
      transact(encode_csr(FUNCT3_CSRRS, csr_list[i], 5'd8, 5'd5), next_rand(), rand_pc());
      read_csr(csr_list[i]);
      transact(encode_csr(FUNCT3_CSRRC, csr_list[i], 5'd9, 5'd5), next_rand(), rand_pc());
      read_csr(csr_list[i]);
      r = next_rand();
      transact(encode_csr(FUNCT3_CSRRSI, csr_list[i], r[4:0] | 5'd1, 5'd5), next_rand(),
               rand_pc());
      transact(encode_csr(FUNCT3_CSRRCI, csr_list[i], r[9:5] | 5'd2, 5'd5), next_rand(),
               rand_pc());
      read_csr(csr_list[i]);
      // x0 source with live rs1 data, and a zero uimm
      transact(encode_csr(FUNCT3_CSRRS, csr_list[i], 5'd0, 5'd5), next_rand(), rand_pc());
      transact(encode_csr(FUNCT3_CSRRCI, csr_list[i], 5'd0, 5'd5), next_rand(), rand_pc());
      read_csr(csr_list[i]);
    end

    // ecall then mret, once with mie set and once clear
    for (int i = 0; i < 2; i++) begin
      // low mtvec bits set, must not show in the redirect
      transact(encode_csr(FUNCT3_CSRRW, MTVEC, 5'd6, 5'd5), next_rand() | 32'h3, rand_pc());
      word               = next_rand();
      word[MSTATUS_MIE]  = (i == 0);
      word[MSTATUS_MPIE] = (i != 0);
      transact(encode_csr(FUNCT3_CSRRW, MSTATUS, 5'd6, 5'd5), word, rand_pc());
      transact(ECALL_INSTR, next_rand(), rand_pc());
      readback_csrs();
      transact(MRET_INSTR, next_rand(), rand_pc());
      read_csr(MSTATUS);
      read_csr(MEPC);
    end

    // nothing here may touch state
    for (int i = 0; i < 2; i++) begin
      r = next_rand();
      transact(encode_csr(FUNCT3_CSRRW, unknown_list[r[1:0]], 5'd4, 5'd5), next_rand(),
               rand_pc());
      transact(encode_csr(FUNCT3_CSRRSI, unknown_list[r[3:2]], 5'd31, 5'd5), next_rand(),
               rand_pc());
      word = next_rand();
      transact({word[31:7], 7'b0010011}, next_rand(), rand_pc());
      // reserved funct3
      transact(encode_csr(3'b100, MSTATUS, 5'd3, 5'd5), next_rand(), rand_pc());
      transact(WFI_INSTR, next_rand(), rand_pc());
    end
    readback_csrs();

    // random mix
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r   = next_rand();
      src = (r[13:12] == 2'b00) ? 5'd0 : r[4:0];
      f3  = csr_funct3[r[10:8] % 3'd6];
      case (r[18:16])
        3'd4: transact(ECALL_INSTR, next_rand(), rand_pc());
        3'd5: transact(MRET_INSTR, next_rand(), rand_pc());
        3'd6: begin
          word = next_rand();
          transact({word[31:7], 7'b0110011}, next_rand(), rand_pc());
        end
        3'd7: transact(encode_csr(f3, unknown_list[r[21:20]], src, 5'd5), next_rand(),
                       rand_pc());
        default: transact(encode_csr(f3, csr_list[r[21:20]], src, 5'd5), next_rand(),
                          rand_pc());
      endcase
    end

    $display("transactions: %0d, errors: %0d", txn_count, error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/trap_unit_top.sv
`timescale 1ns/10ps
`default_nettype none

module trap_unit_top
  import sys_op_pkg::*;
#(
  parameter int              XLEN        = 32,
  parameter logic [XLEN-1:0] MTVEC_RESET = '0
) (
  input  logic            clk,
  input  logic            i_rst_n,
  input  logic            i_req,
  input  logic [31:0]     i_instr,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_rs1_data,
  output logic            o_ack,
  output logic [XLEN-1:0] o_rd_data,
  output logic            o_redirect,
  output logic [XLEN-1:0] o_target_pc,
  output logic            o_illegal
);

  // decoder to controller
  sys_op_e         dec_op;
  logic [11:0]     dec_csr_addr;
  logic            dec_use_imm;
  logic [4:0]      dec_imm;
  logic            dec_no_write;

  // controller to csr file
  logic [11:0]     csr_raddr;
  logic [XLEN-1:0] csr_rdata;
  logic            csr_valid;
  logic            csr_wen;
  logic [11:0]     csr_waddr;
  logic [XLEN-1:0] csr_wdata;
  logic            trap_ecall;
  logic            trap_mret;
  logic [XLEN-1:0] trap_pc;
  // redirect sources back up
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mepc_q;

  sys_decoder u_decoder (
    .i_instr    (i_instr),
    .o_op       (dec_op),
    .o_csr_addr (dec_csr_addr),
    .o_use_imm  (dec_use_imm),
    .o_imm      (dec_imm),
    .o_no_write (dec_no_write)
  );

  sys_exec_ctrl #(
    .XLEN (XLEN)
  ) u_ctrl (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_req        (i_req),
    .i_pc         (i_pc),
    .i_rs1_data   (i_rs1_data),
    .o_ack        (o_ack),
    .o_rd_data    (o_rd_data),
    .o_redirect   (o_redirect),
    .o_target_pc  (o_target_pc),
    .o_illegal    (o_illegal),
    .i_op         (dec_op),
    .i_csr_addr   (dec_csr_addr),
    .i_use_imm    (dec_use_imm),
    .i_imm        (dec_imm),
    .i_no_write   (dec_no_write),
    .o_csr_raddr  (csr_raddr),
    .i_csr_rdata  (csr_rdata),
    .i_csr_rvalid (csr_valid),
    .o_csr_wen    (csr_wen),
    .o_csr_waddr  (csr_waddr),
    .o_csr_wdata  (csr_wdata),
    .o_trap_ecall (trap_ecall),
    .o_trap_mret  (trap_mret),
    .o_trap_pc    (trap_pc),
    .i_mtvec      (mtvec_q),
    .i_mepc       (mepc_q)
  );

  csr_file #(
    .XLEN        (XLEN),
    .MTVEC_RESET (MTVEC_RESET)
  ) u_csr_file (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_raddr  (csr_raddr),
    .o_rdata  (csr_rdata),
    .o_rvalid (csr_valid),
    .i_wen    (csr_wen),
    .i_waddr  (csr_waddr),
    .i_wdata  (csr_wdata),
    .i_ecall  (trap_ecall),
    .i_mret   (trap_mret),
    .i_pc     (trap_pc),
    .o_mtvec  (mtvec_q),
    .o_mepc   (mepc_q)
  );

endmodule

`default_nettype wire

//--- source/sys_exec_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module sys_exec_ctrl
  import sys_op_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            i_rst_n,
  // pipeline side
  input  logic            i_req,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_rs1_data,
  output logic            o_ack,
  output logic [XLEN-1:0] o_rd_data,
  output logic            o_redirect,
  output logic [XLEN-1:0] o_target_pc,
  output logic            o_illegal,
  // decoder
  input  sys_op_e         i_op,
  input  logic [11:0]     i_csr_addr,
  input  logic            i_use_imm,
  input  logic [4:0]      i_imm,
  input  logic            i_no_write,
  // csr file
  output logic [11:0]     o_csr_raddr,
  input  logic [XLEN-1:0] i_csr_rdata,
  input  logic            i_csr_rvalid,
  output logic            o_csr_wen,
  output logic [11:0]     o_csr_waddr,
  output logic [XLEN-1:0] o_csr_wdata,
  output logic            o_trap_ecall,
  output logic            o_trap_mret,
  output logic [XLEN-1:0] o_trap_pc,
  input  logic [XLEN-1:0] i_mtvec,
  input  logic [XLEN-1:0] i_mepc
);

  ctrl_state_e     state_q;
  sys_op_e         op_q;
  // operands captured at request time
  logic [11:0]     addr_q;
  logic            use_imm_q;
  logic [4:0]      imm_q;
  logic            no_write_q;
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] rs1_q;

  logic            exec;
  logic            is_csr;
  logic            illegal;
  logic [XLEN-1:0] operand;

  assign exec    = (state_q == ST_EXEC);
  assign is_csr  = (op_q == OP_CSRRW) || (op_q == OP_CSRRS) || (op_q == OP_CSRRC);
  // unknown address or no SYSTEM op at all
  assign illegal = (op_q == OP_NONE) || !i_csr_rvalid;
  assign operand = use_imm_q ? {{(XLEN-5){1'b0}}, imm_q} : rs1_q;

  // new csr value
  always_comb begin
    case (op_q)
      OP_CSRRW: o_csr_wdata = operand;
      OP_CSRRS: o_csr_wdata = i_csr_rdata | operand;
      OP_CSRRC: o_csr_wdata = i_csr_rdata & ~operand;
      default:  o_csr_wdata = i_csr_rdata;
    endcase
  end

  assign o_csr_raddr  = addr_q;
  assign o_csr_waddr  = addr_q;
  // single-cycle pulses, only while executing
  assign o_csr_wen    = exec && is_csr && !illegal && !no_write_q;
  assign o_trap_ecall = exec && (op_q == OP_ECALL);
  assign o_trap_mret  = exec && (op_q == OP_MRET);
  assign o_trap_pc    = pc_q;

  // decoded fields and operands of the accepted request
  always_ff @(posedge clk) begin
    if ((state_q == ST_IDLE) && i_req) begin
      addr_q     <= i_csr_addr;
      use_imm_q  <= i_use_imm;
      imm_q      <= i_imm;
      no_write_q <= i_no_write;
      pc_q       <= i_pc;
      rs1_q      <= i_rs1_data;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q     <= ST_IDLE;
      op_q        <= OP_NONE;
      o_ack       <= 1'b0;
      o_rd_data   <= '0;
      o_redirect  <= 1'b0;
      o_target_pc <= '0;
      o_illegal   <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (i_req) begin
            op_q    <= i_op;
            state_q <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          // old value goes to rd, traps return zero
          o_rd_data   <= (is_csr && !illegal) ? i_csr_rdata : '0;
          o_illegal   <= illegal;
          o_redirect  <= (op_q == OP_ECALL) || (op_q == OP_MRET);
          // mtvec base only, direct mode
          o_target_pc <= (op_q == OP_ECALL) ? {i_mtvec[XLEN-1:2], 2'b00} :
                         (op_q == OP_MRET)  ? i_mepc : '0;
          o_ack       <= 1'b1;
          state_q     <= ST_ACK;
        end
        ST_ACK: begin
          // hold results until requester lets go
          if (!i_req) begin
            o_ack   <= 1'b0;
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // requester holds i_req until it sees the ack
  a_ack_needs_req: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    $rose(o_ack) |-> i_req
  );

  // a pulse only in the cycle right before the ack rises
  a_pulse_in_exec: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    (o_csr_wen || o_trap_ecall || o_trap_mret) |-> !o_ack ##1 o_ack
  );

endmodule

`default_nettype wire

//--- source/csr_file.sv
`timescale 1ns/10ps
`default_nettype none

module csr_file
  import csr_pkg::*;
#(
  parameter int              XLEN        = 32,
  parameter logic [XLEN-1:0] MTVEC_RESET = '0
) (
  input  logic            clk,
  input  logic            i_rst_n,
  // read port
  input  logic [11:0]     i_raddr,
  output logic [XLEN-1:0] o_rdata,
  output logic            o_rvalid,
  // write port
  input  logic            i_wen,
  input  logic [11:0]     i_waddr,
  input  logic [XLEN-1:0] i_wdata,
  // trap side effects
  input  logic            i_ecall,
  input  logic            i_mret,
  input  logic [XLEN-1:0] i_pc,
  // redirect sources
  output logic [XLEN-1:0] o_mtvec,
  output logic [XLEN-1:0] o_mepc
);

  logic [XLEN-1:0] mstatus_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;

  // address check for the write side
  logic            waddr_ok;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mstatus_q <= XLEN'(MSTATUS_RESET);
      mtvec_q   <= MTVEC_RESET;
      mepc_q    <= XLEN'(MEPC_RESET);
      mcause_q  <= XLEN'(MCAUSE_RESET);
    end else if (i_ecall) begin
      // trap entry, save pc and stack the interrupt enable
      mepc_q                                <= i_pc;
      mcause_q                              <= XLEN'(CAUSE_ECALL_M);
      mstatus_q[MSTATUS_MPIE]               <= mstatus_q[MSTATUS_MIE];
      mstatus_q[MSTATUS_MIE]                <= 1'b0;
      mstatus_q[MSTATUS_MPP_HI:MSTATUS_MPP_LO] <= MPP_MACHINE;
    end else if (i_mret) begin
      // trap return, pop the interrupt enable
      mstatus_q[MSTATUS_MIE]                <= mstatus_q[MSTATUS_MPIE];
      mstatus_q[MSTATUS_MPIE]               <= 1'b1;
      mstatus_q[MSTATUS_MPP_HI:MSTATUS_MPP_LO] <= MPP_USER;
    end else if (i_wen) begin
      case (csr_addr_e'(i_waddr))
        MSTATUS: mstatus_q <= i_wdata;
        MTVEC:   mtvec_q   <= i_wdata;
        MEPC:    mepc_q    <= i_wdata;
        MCAUSE:  mcause_q  <= i_wdata;
        default: mcause_q  <= mcause_q;
      endcase
    end
  end

  // combinational read mux
  always_comb begin
    o_rvalid = 1'b1;
    case (csr_addr_e'(i_raddr))
      MSTATUS: o_rdata = mstatus_q;
      MTVEC:   o_rdata = mtvec_q;
      MEPC:    o_rdata = mepc_q;
      MCAUSE:  o_rdata = mcause_q;
      default: begin
        o_rdata  = '0;
        o_rvalid = 1'b0;
      end
    endcase
  end

  always_comb begin
    case (csr_addr_e'(i_waddr))
      MSTATUS, MTVEC, MEPC, MCAUSE: waddr_ok = 1'b1;
      default:                      waddr_ok = 1'b0;
    endcase
  end

  assign o_mtvec = mtvec_q;
  assign o_mepc  = mepc_q;

  // controller must not mix a csr write with a trap update
  a_no_wen_with_trap: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    i_wen |-> !(i_ecall || i_mret)
  );

  // entry and return never in the same cycle
  a_ecall_mret_excl: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    !(i_ecall && i_mret)
  );

  // illegal addresses are filtered upstream
  a_wen_valid_addr: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    i_wen |-> waddr_ok
  );

endmodule

`default_nettype wire

//--- source/sys_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module sys_decoder
  import sys_op_pkg::*;
  import csr_pkg::*;
(
  input  logic [31:0] i_instr,
  output sys_op_e     o_op,
  output logic [11:0] o_csr_addr,
  output logic        o_use_imm,
  output logic [4:0]  o_imm,
  output logic        o_no_write
);

  // instruction fields
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [4:0]  rs1_field;
  logic [4:0]  rd_field;
  logic [11:0] funct12;
  logic        priv_ok;
  logic        is_trap;

  assign opcode    = i_instr[6:0];
  assign rd_field  = i_instr[11:7];
  assign funct3    = i_instr[14:12];
  assign rs1_field = i_instr[19:15];
  assign funct12   = i_instr[31:20];

  // ecall and mret need rd and rs1 both zero
  assign priv_ok = (rs1_field == 5'd0) && (rd_field == 5'd0);

  always_comb begin
    o_op = OP_NONE;
    if (opcode == OPC_SYSTEM) begin
      case (funct3)
        FUNCT3_PRIV: begin
          if (priv_ok && (funct12 == FUNCT12_ECALL)) begin
            o_op = OP_ECALL;
          end else if (priv_ok && (funct12 == FUNCT12_MRET)) begin
            o_op = OP_MRET;
          end
        end
        FUNCT3_CSRRW, FUNCT3_CSRRWI: o_op = OP_CSRRW;
        FUNCT3_CSRRS, FUNCT3_CSRRSI: o_op = OP_CSRRS;
        FUNCT3_CSRRC, FUNCT3_CSRRCI: o_op = OP_CSRRC;
        // funct3 100 is reserved
        default: o_op = OP_NONE;
      endcase
    end
  end

  assign is_trap = (o_op == OP_ECALL) || (o_op == OP_MRET);

  // traps point at mstatus, the csr they both modify
  // so the controller's address check passes for them
  assign o_csr_addr = is_trap ? MSTATUS : funct12;

  // funct3 bit 2 selects the uimm forms
  assign o_use_imm = funct3[2];
  // uimm shares the rs1 slot
  assign o_imm     = rs1_field;

  // set/clear with x0 or zero uimm only read
  assign o_no_write = ((o_op == OP_CSRRS) || (o_op == OP_CSRRC)) &&
                      (rs1_field == 5'd0);

endmodule

`default_nettype wire

//--- source/sys_op_pkg.sv
`default_nettype none

package sys_op_pkg;

  // base opcode of the SYSTEM class
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // funct3 codes within SYSTEM
  localparam logic [2:0] FUNCT3_PRIV   = 3'b000;
  localparam logic [2:0] FUNCT3_CSRRW  = 3'b001;
  localparam logic [2:0] FUNCT3_CSRRS  = 3'b010;
  localparam logic [2:0] FUNCT3_CSRRC  = 3'b011;
  localparam logic [2:0] FUNCT3_CSRRWI = 3'b101;
  localparam logic [2:0] FUNCT3_CSRRSI = 3'b110;
  localparam logic [2:0] FUNCT3_CSRRCI = 3'b111;

  // funct12 patterns for privileged ops
  localparam logic [11:0] FUNCT12_ECALL = 12'h000;
  localparam logic [11:0] FUNCT12_MRET  = 12'h302;

  // decoded operation, immediate forms fold into the register ones
  typedef enum logic [2:0] {
    OP_NONE,
    OP_CSRRW,
    OP_CSRRS,
    OP_CSRRC,
    OP_ECALL,
    OP_MRET
  } sys_op_e;

  // controller handshake states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXEC,
    ST_ACK
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- source/csr_pkg.sv
`default_nettype none

package csr_pkg;

  // machine csr addresses handled by the unit
  typedef enum logic [11:0] {
    MSTATUS = 12'h300,
    MTVEC   = 12'h305,
    MEPC    = 12'h341,
    MCAUSE  = 12'h342
  } csr_addr_e;

  // mstatus field positions
  localparam int MSTATUS_MIE    = 3;
  localparam int MSTATUS_MPIE   = 7;
  localparam int MSTATUS_MPP_LO = 11;
  localparam int MSTATUS_MPP_HI = 12;

  // mpp encodings
  // machine on trap entry, user after mret
  localparam logic [1:0] MPP_MACHINE = 2'b11;
  localparam logic [1:0] MPP_USER    = 2'b00;

  // environment call from m-mode
  localparam int unsigned CAUSE_ECALL_M = 11;

  // reset values, mtvec comes from the top level
  localparam int unsigned MSTATUS_RESET = 0;
  localparam int unsigned MEPC_RESET    = 0;
  localparam int unsigned MCAUSE_RESET  = 0;

endpackage

`default_nettype wire
